// File: Bender.yml
package:
  name: ros2_host

sources:
  - files:
      - rtl/ros2_host_pkg.sv
      - rtl/buffer_arbiter.sv
      - rtl/app_data_arbiter.sv
      - rtl/rx_size_monitor.sv
      - rtl/tx_scheduler.sv
      - rtl/ros2_host_top.sv
  - target: test
    files:
      - tb/ros2_host_sva.sv
      - tb/ros2_host_tb.sv

// File: rtl/app_data_arbiter.sv
module app_data_arbiter (
    input  logic clk,
    input  logic rst_n,

    input  logic enable,
    input  logic ip_req,
    input  logic ip_rel,
    input  logic cpu_req,
    input  logic cpu_rel,

    output logic ip_grant,
    output logic cpu_grant
);

    import ros2_host_pkg::*;

    app_grant_e state;
    app_grant_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            APP_NONE: begin
                if (ip_req) begin
                    state_nxt = APP_IP;     // Engine wins ties
                end else if (cpu_req) begin
                    state_nxt = APP_CPU;
                end
            end
            APP_IP: begin
                if (ip_rel) begin
                    state_nxt = APP_NONE;
                end
            end
            APP_CPU: begin
                if (cpu_rel) begin
                    state_nxt = APP_NONE;
                end
            end
            default: state_nxt = APP_NONE;  // Illegal encoding
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= APP_NONE;
        end else begin
            state <= state_nxt;
        end
    end

    assign ip_grant  = enable & (state == APP_IP);
    assign cpu_grant = enable & (state == APP_CPU);

endmodule

// File: rtl/buffer_arbiter.sv
module buffer_arbiter #(
    parameter ros2_host_pkg::owner_e RESET_OWNER = ros2_host_pkg::OWNER_IP
) (
    input  logic clk,
    input  logic rst_n,

    input  logic enable,
    input  logic ip_rel,
    input  logic cpu_rel,

    output logic ip_grant,
    output logic cpu_grant
);

    import ros2_host_pkg::*;

    owner_e owner;

    // Ownership only moves on a release by the current owner
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner <= RESET_OWNER;
        end else begin
            case (owner)
                OWNER_IP: begin
                    if (ip_rel) begin
                        owner <= OWNER_CPU;
                    end
                end
                OWNER_CPU: begin
                    if (cpu_rel) begin
                        owner <= OWNER_IP;
                    end
                end
                default: owner <= RESET_OWNER;
            endcase
        end
    end

    assign ip_grant  = enable & (owner == OWNER_IP);
    assign cpu_grant = enable & (owner == OWNER_CPU);

endmodule

// File: rtl/ros2_host_pkg.sv
package ros2_host_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Buffer geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int RXBUF_AWIDTH = 10;
    localparam int TXBUF_AWIDTH = 6;

    typedef logic [31:0]             buf_word_t;
    typedef logic [RXBUF_AWIDTH-1:0] rxbuf_addr_t;
    typedef logic [TXBUF_AWIDTH-1:0] txbuf_addr_t;
    typedef logic [15:0]             rx_size_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Ownership states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic {
        OWNER_IP  = 1'b0,
        OWNER_CPU = 1'b1
    } owner_e;

    typedef enum logic [1:0] {
        APP_NONE = 2'b00,
        APP_IP   = 2'b01,
        APP_CPU  = 2'b10
    } app_grant_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host demo constants
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam rxbuf_addr_t RX_SIZE_WORD = rxbuf_addr_t'(1); // Size in upper half

    localparam int TX_DESC_WORDS = 5;

    // Outgoing datagram descriptor as read by the engine
    localparam buf_word_t TX_DESC [TX_DESC_WORDS] = '{
        32'h0a01a8c0,   // Destination IP
        32'h045704d2,   // Ports
        32'h00000007,   // Length
        32'h626f6f66,   // Payload
        32'h000a7261
    };

    localparam int LED_RED_MAX   = 10;
    localparam int LED_GREEN_MAX = 20;

endpackage

// File: rtl/ros2_host_top.sv
module ros2_host_top #(
    parameter int TX_PERIOD_LOG2 = 27
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       enable,

    // Application-data record
    input  logic                       app_ip_req,
    input  logic                       app_ip_rel,
    input  logic                       app_cpu_req,
    input  logic                       app_cpu_rel,
    output logic                       app_ip_grant,
    output logic                       app_cpu_grant,

    // UDP receive buffer
    input  logic                       rxbuf_ip_rel,
    input  logic                       rxbuf_we,
    input  ros2_host_pkg::rxbuf_addr_t rxbuf_addr,
    input  ros2_host_pkg::buf_word_t   rxbuf_wdata,
    output logic                       rxbuf_ip_grant,

    // UDP transmit buffer
    input  logic                       txbuf_ip_rel,
    input  ros2_host_pkg::txbuf_addr_t txbuf_addr,
    output logic                       txbuf_ip_grant,
    output ros2_host_pkg::buf_word_t   txbuf_rdata,

    output logic                       led_r,
    output logic                       led_g,
    output logic                       led_b
);

    logic rxbuf_cpu_grant;
    logic rxbuf_cpu_rel;
    logic txbuf_cpu_rel;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Arbiters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    app_data_arbiter app_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .ip_req    (app_ip_req),
        .ip_rel    (app_ip_rel),
        .cpu_req   (app_cpu_req),
        .cpu_rel   (app_cpu_rel),
        .ip_grant  (app_ip_grant),
        .cpu_grant (app_cpu_grant)
    );

    buffer_arbiter #(
        .RESET_OWNER (ros2_host_pkg::OWNER_IP)    // Engine receives first
    ) rxbuf_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .ip_rel    (rxbuf_ip_rel),
        .cpu_rel   (rxbuf_cpu_rel),
        .ip_grant  (rxbuf_ip_grant),
        .cpu_grant (rxbuf_cpu_grant)
    );

    buffer_arbiter #(
        .RESET_OWNER (ros2_host_pkg::OWNER_CPU)   // Host fills first
    ) txbuf_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .ip_rel    (txbuf_ip_rel),
        .cpu_rel   (txbuf_cpu_rel),
        .ip_grant  (txbuf_ip_grant),
        .cpu_grant ()
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    rx_size_monitor rx_mon (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_grant   (rxbuf_cpu_grant),
        .rxbuf_we    (rxbuf_we),
        .rxbuf_addr  (rxbuf_addr),
        .rxbuf_wdata (rxbuf_wdata),
        .cpu_rel     (rxbuf_cpu_rel),
        .led_r       (led_r),
        .led_g       (led_g),
        .led_b       (led_b)
    );

    tx_scheduler #(
        .TX_PERIOD_LOG2 (TX_PERIOD_LOG2)
    ) tx_sched (
        .clk         (clk),
        .rst_n       (rst_n),
        .txbuf_addr  (txbuf_addr),
        .cpu_rel     (txbuf_cpu_rel),
        .txbuf_rdata (txbuf_rdata)
    );

endmodule

// File: rtl/rx_size_monitor.sv
module rx_size_monitor (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic                       cpu_grant,
    input  logic                       rxbuf_we,
    input  ros2_host_pkg::rxbuf_addr_t rxbuf_addr,
    input  ros2_host_pkg::buf_word_t   rxbuf_wdata,

    output logic                       cpu_rel,
    output logic                       led_r,
    output logic                       led_g,
    output logic                       led_b
);

    import ros2_host_pkg::*;

    rx_size_t last_rx_size;

    // Hand the buffer straight back once granted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cpu_rel <= 1'b0;
        end else begin
            cpu_rel <= cpu_grant;
        end
    end

    // Engine writes the datagram size into the header word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_rx_size <= '0;
        end else if (rxbuf_we && (rxbuf_addr == RX_SIZE_WORD)) begin
            last_rx_size <= rxbuf_wdata[31:16];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Size class display
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        led_r = (last_rx_size >= rx_size_t'(1)) &&
                (last_rx_size <= rx_size_t'(LED_RED_MAX));
        led_g = (last_rx_size >  rx_size_t'(LED_RED_MAX)) &&
                (last_rx_size <= rx_size_t'(LED_GREEN_MAX));
        led_b = (last_rx_size >  rx_size_t'(LED_GREEN_MAX));
    end

endmodule

// File: rtl/tx_scheduler.sv
module tx_scheduler #(
    parameter int TX_PERIOD_LOG2 = 27
) (
    input  logic                       clk,
    input  logic                       rst_n,

    input  ros2_host_pkg::txbuf_addr_t txbuf_addr,

    output logic                       cpu_rel,
    output ros2_host_pkg::buf_word_t   txbuf_rdata
);

    import ros2_host_pkg::*;

    localparam int CNT_W = TX_PERIOD_LOG2 + 1;

    logic [CNT_W-1:0] tx_cnt;
    logic             period_done;
    buf_word_t        desc_word;

    assign period_done = tx_cnt[TX_PERIOD_LOG2];   // Counter hit 2**N

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Periodic hand-off of the transmit buffer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_cnt  <= '0;
            cpu_rel <= 1'b0;
        end else if (period_done) begin
            tx_cnt  <= '0;
            cpu_rel <= 1'b1;   // One-cycle release pulse
        end else begin
            tx_cnt  <= tx_cnt + 1'b1;
            cpu_rel <= 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Descriptor table read port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        desc_word = '0;
        for (int i = 0; i < TX_DESC_WORDS; i++) begin
            if (txbuf_addr == txbuf_addr_t'(i)) begin
                desc_word = TX_DESC[i];
            end
        end
    end

    // Zero beyond the table end
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txbuf_rdata <= '0;
        end else begin
            txbuf_rdata <= desc_word;
        end
    end

endmodule

// File: tb/ros2_host_sva.sv
module ros2_host_sva (
    input logic clk,
    input logic rst_n,
    input logic enable,
    input logic app_ip_grant,
    input logic app_cpu_grant,
    input logic rxbuf_ip_grant,
    input logic rxbuf_cpu_grant,
    input logic txbuf_ip_grant
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;   // Summed into the final report

    app_one_owner: assert property (@(posedge clk) disable iff (!rst_n)
        !(app_ip_grant && app_cpu_grant))
    else begin
        $error("application-data record granted to both sides");
        fail_count++;
    end

    // Receive buffer always has exactly one holder
    rx_one_owner: assert property (@(posedge clk) disable iff (!rst_n)
        enable |-> (rxbuf_ip_grant ^ rxbuf_cpu_grant))
    else begin
        $error("receive buffer held by none or both sides");
        fail_count++;
    end

    grants_gated: assert property (@(posedge clk) disable iff (!rst_n)
        !enable |-> !(app_ip_grant || app_cpu_grant || rxbuf_ip_grant ||
                      rxbuf_cpu_grant || txbuf_ip_grant))
    else begin
        $error("grant high while enable is low");
        fail_count++;
    end

endmodule

bind ros2_host_top ros2_host_sva sva (
    .clk             (clk),
    .rst_n           (rst_n),
    .enable          (enable),
    .app_ip_grant    (app_ip_grant),
    .app_cpu_grant   (app_cpu_grant),
    .rxbuf_ip_grant  (rxbuf_ip_grant),
    .rxbuf_cpu_grant (rxbuf_cpu_grant),
    .txbuf_ip_grant  (txbuf_ip_grant)
);

// File: tb/ros2_host_tb.sv
module ros2_host_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import ros2_host_pkg::*;

    localparam int TX_LOG2      = 6;
    localparam int TX_PULSE_GAP = 2**TX_LOG2 + 1;   // Scheduler pulse spacing
    localparam int APP_CYCLES   = 300;
    localparam int RX_HANDOFFS  = 24;
    localparam int SIZE_CYCLES  = 200;
    localparam int TX_PERIODS   = 4;
    localparam int EN_STRETCHES = 3;
    localparam int MAX_CYCLES   = 3000;             // Tests need about 1100

    logic        clk = 1'b0;
    logic        rst_n;
    logic        enable;
    logic        app_ip_req, app_ip_rel, app_cpu_req, app_cpu_rel;
    logic        app_ip_grant, app_cpu_grant;
    logic        rxbuf_ip_rel, rxbuf_we, rxbuf_ip_grant;
    rxbuf_addr_t rxbuf_addr;
    buf_word_t   rxbuf_wdata;
    logic        txbuf_ip_rel, txbuf_ip_grant;
    txbuf_addr_t txbuf_addr;
    buf_word_t   txbuf_rdata;
    logic        led_r, led_g, led_b;

    // Reference model state
    app_grant_e  m_app;
    owner_e      m_rx_owner;
    owner_e      m_tx_owner;
    logic        m_rx_rel;
    logic        m_tx_rel;
    rx_size_t    m_size;
    int          m_tx_cnt;
    buf_word_t   m_rdata;

    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle_cnt = 0;
    logic [31:0] lcg_state = 32'h51c5b361;

    ros2_host_top #(.TX_PERIOD_LOG2(TX_LOG2)) dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Random numbers and expected values
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return (rand_word() >> 8) % n;   // Low LCG bits are weak
    endfunction

    function automatic buf_word_t desc_expect(input txbuf_addr_t a);
        if (a < TX_DESC_WORDS) return TX_DESC[a];
        return '0;
    endfunction

    // LED pattern {r, g, b} for a datagram size
    function automatic logic [2:0] led_class(input rx_size_t size);
        if (size == '0) return 3'b000;
        if (size <= rx_size_t'(LED_RED_MAX)) return 3'b100;
        if (size <= rx_size_t'(LED_GREEN_MAX)) return 3'b010;
        return 3'b001;
    endfunction

    task automatic check_grant(input logic actual, input logic expected, input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic check_word(input buf_word_t actual, input buf_word_t expected,
                              input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_size(input rx_size_t actual, input rx_size_t expected,
                              input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %0t: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cycle model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic model_step();
        app_grant_e app_n;
        logic       rx_host;
        logic       tx_host;
        logic       pulse;
        if (!rst_n) begin
            m_app      = APP_NONE;
            m_rx_owner = OWNER_IP;
            m_tx_owner = OWNER_CPU;
            m_rx_rel   = 1'b0;
            m_tx_rel   = 1'b0;
            m_size     = '0;
            m_tx_cnt   = 0;
            m_rdata    = '0;
        end else begin
            app_n = m_app;
            if (m_app == APP_NONE && app_ip_req) app_n = APP_IP;
            else if (m_app == APP_NONE && app_cpu_req) app_n = APP_CPU;
            else if (m_app == APP_IP && app_ip_rel) app_n = APP_NONE;
            else if (m_app == APP_CPU && app_cpu_rel) app_n = APP_NONE;
            m_app = app_n;

            rx_host = (m_rx_owner == OWNER_CPU);
            tx_host = (m_tx_owner == OWNER_CPU);
            if (!rx_host && rxbuf_ip_rel) m_rx_owner = OWNER_CPU;
            if (rx_host && m_rx_rel) m_rx_owner = OWNER_IP;
            if (!tx_host && txbuf_ip_rel) m_tx_owner = OWNER_CPU;
            if (tx_host && m_tx_rel) m_tx_owner = OWNER_IP;
            m_rx_rel = enable && rx_host;   // Host sees the gated grant

            if (rxbuf_we && rxbuf_addr == RX_SIZE_WORD) m_size = rxbuf_wdata[31:16];

            pulse    = (m_tx_cnt == 2**TX_LOG2);
            m_tx_cnt = pulse ? 0 : m_tx_cnt + 1;
            m_tx_rel = pulse;
            m_rdata  = desc_expect(txbuf_addr);
        end
    endtask

    task automatic compare_all();
        logic [2:0] leds;
        leds = led_class(m_size);
        check_grant(app_ip_grant, enable && m_app == APP_IP, "app_ip_grant");
        check_grant(app_cpu_grant, enable && m_app == APP_CPU, "app_cpu_grant");
        check_grant(rxbuf_ip_grant, enable && m_rx_owner == OWNER_IP, "rxbuf_ip_grant");
        check_grant(txbuf_ip_grant, enable && m_tx_owner == OWNER_IP, "txbuf_ip_grant");
        check_grant(led_r, leds[2], "led_r");
        check_grant(led_g, leds[1], "led_g");
        check_grant(led_b, leds[0], "led_b");
        check_size(dut.rx_mon.last_rx_size, m_size, "size register");
        check_word(txbuf_rdata, m_rdata, "txbuf_rdata");
    endtask

    // Edge, model update, compare, then leave 2 ns after the edge
    task automatic tick();
        @(posedge clk);
        model_step();
        #1;
        compare_all();
        #1;
    endtask

    task automatic drive_app_random();
        app_ip_req  = (rand_below(3) == 0);
        app_cpu_req = (rand_below(3) == 0);
        app_ip_rel  = (rand_below(4) == 0);
        app_cpu_rel = (rand_below(4) == 0);
    endtask

    task automatic read_step();
        txbuf_addr_t a;
        if (rand_below(4) == 0) a = txbuf_addr_t'(rand_word());
        else a = txbuf_addr_t'(rand_below(8));
        txbuf_addr = a;
        tick();
        check_word(txbuf_rdata, desc_expect(a), "descriptor read");
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        tests_run++;
        if (errors == errs_at_start) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL, %0d errors", tests_run, name, errors - errs_at_start);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int         errs0;
        int         len;
        int         hold;
        int         ties;
        int         last_rise;
        logic       hit;
        logic [2:0] leds_before;
        buf_word_t  wdata;

        rst_n = 1'b0;
        enable = 1'b1;
        {app_ip_req, app_ip_rel, app_cpu_req, app_cpu_rel} = '0;
        rxbuf_ip_rel = 1'b0;
        rxbuf_we     = 1'b0;
        rxbuf_addr   = '0;
        rxbuf_wdata  = '0;
        txbuf_ip_rel = 1'b0;
        txbuf_addr   = '0;
        repeat (10) tick();
        rst_n = 1'b1;

        errs0 = errors;
        check_grant(txbuf_ip_grant, 1'b0, "txbuf_ip_grant after reset");
        check_grant(rxbuf_ip_grant, 1'b1, "rxbuf_ip_grant after reset");
        check_grant(app_ip_grant | app_cpu_grant, 1'b0, "app grants after reset");
        check_grant(led_r | led_g | led_b, 1'b0, "LEDs after reset");
        check_word(txbuf_rdata, '0, "txbuf_rdata after reset");
        finish_test("reset state", errs0);

        errs0 = errors;
        ties = 0;
        for (int i = 0; i < APP_CYCLES; i++) begin
            drive_app_random();
            hit = (m_app == APP_NONE) && app_ip_req && app_cpu_req;
            tick();
            if (hit) begin
                ties++;
                check_grant(app_ip_grant, 1'b1, "engine priority on tie");
            end
        end
        {app_ip_req, app_ip_rel, app_cpu_req, app_cpu_rel} = '0;
        finish_test($sformatf("app arbitration, %0d ties", ties), errs0);

        errs0 = errors;
        for (int i = 0; i < RX_HANDOFFS; i++) begin
            repeat (1 + rand_below(5)) tick();
            hold = 1 + rand_below(2);   // Second cycle of release is ignored
            rxbuf_ip_rel = 1'b1;
            tick();
            check_grant(rxbuf_ip_grant, 1'b0, "rx grant in first host cycle");
            if (hold == 1) rxbuf_ip_rel = 1'b0;
            tick();
            check_grant(rxbuf_ip_grant, 1'b0, "rx grant in second host cycle");
            rxbuf_ip_rel = 1'b0;
            tick();
            check_grant(rxbuf_ip_grant, 1'b1, "rx grant back with engine");
        end
        finish_test("receive hand-off", errs0);

        errs0 = errors;
        for (int i = 0; i < SIZE_CYCLES; i++) begin
            rxbuf_we = (rand_below(2) == 0);
            if (rand_below(3) == 0) rxbuf_addr = RX_SIZE_WORD;
            else rxbuf_addr = rxbuf_addr_t'(rand_word());
            wdata = rand_word();
            if (rxbuf_addr == RX_SIZE_WORD) wdata[31:16] = rx_size_t'(rand_below(41));
            rxbuf_wdata = wdata;
            hit = rxbuf_we && (rxbuf_addr == RX_SIZE_WORD);
            leds_before = {led_r, led_g, led_b};
            tick();
            if (hit) begin
                check_size(dut.rx_mon.last_rx_size, wdata[31:16], "captured size");
            end else begin
                check_grant(led_r, leds_before[2], "led_r unchanged");
                check_grant(led_g, leds_before[1], "led_g unchanged");
                check_grant(led_b, leds_before[0], "led_b unchanged");
            end
        end
        rxbuf_we = 1'b0;
        finish_test("size capture", errs0);

        errs0 = errors;
        if (txbuf_ip_grant) begin
            txbuf_ip_rel = 1'b1;
            tick();
            txbuf_ip_rel = 1'b0;
        end
        last_rise = -1;
        for (int p = 0; p < TX_PERIODS; p++) begin
            len = 0;
            while (!txbuf_ip_grant && len < TX_PULSE_GAP + 2) begin
                read_step();
                len++;
            end
            if (!txbuf_ip_grant) begin
                errors++;
                $display("Transmit grant did not arrive within %0d cycles", len);
            end else begin
                if (last_rise >= 0) begin
                    check_word(buf_word_t'(cycle_cnt - last_rise), buf_word_t'(TX_PULSE_GAP),
                               "transmit grant spacing");
                end
                last_rise = cycle_cnt;
                repeat (1 + rand_below(10)) read_step();
                txbuf_ip_rel = 1'b1;
                tick();
                txbuf_ip_rel = 1'b0;
                check_grant(txbuf_ip_grant, 1'b0, "tx grant after hand-back");
            end
        end
        finish_test("transmit cycle", errs0);

        errs0 = errors;
        for (int s = 0; s < EN_STRETCHES; s++) begin
            len = 5 + rand_below(20);
            enable = 1'b0;
            for (int i = 0; i < len; i++) begin
                drive_app_random();
                rxbuf_ip_rel = (rand_below(4) == 0);
                txbuf_ip_rel = (rand_below(4) == 0);
                tick();
                check_grant(app_ip_grant | app_cpu_grant | rxbuf_ip_grant | txbuf_ip_grant,
                            1'b0, "grant while disabled");
            end
            enable = 1'b1;
            for (int i = 0; i < 16; i++) begin
                drive_app_random();
                rxbuf_ip_rel = (rand_below(4) == 0);
                txbuf_ip_rel = (rand_below(4) == 0);
                tick();
            end
        end
        {app_ip_req, app_ip_rel, app_cpu_req, app_cpu_rel} = '0;
        rxbuf_ip_rel = 1'b0;
        txbuf_ip_rel = 1'b0;
        repeat (4) tick();
        finish_test("enable gating", errs0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, checks, errors, dut.sva.fail_count);
        if (errors == 0 && dut.sva.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: verilog.f
rtl/ros2_host_pkg.sv
rtl/buffer_arbiter.sv
rtl/app_data_arbiter.sv
rtl/rx_size_monitor.sv
rtl/tx_scheduler.sv
rtl/ros2_host_top.sv
tb/ros2_host_sva.sv
tb/ros2_host_tb.sv
